//--- cpu_top.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = cpu_top.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int TIMEOUT = 2000;   // Cycles allowed per wait

  logic                    clk;
  logic                    reset;
  logic [KEYBITS-1:0]      key;
  logic                    boot_we;
  logic [IMEMADDRBITS-1:0] boot_addr;
  logic [INSTBITS-1:0]     boot_data;
  logic [HEXBITS-1:0]      hex;
  logic [LEDRBITS-1:0]     ledr;

  logic [INSTBITS-1:0] prog [$];   // Program being assembled
  word_t               lcg_state;
  int                  checks;
  int                  errors;

  cpu_top dut0 (
    .clk(clk), .reset(reset), .key(key), .boot_we(boot_we), .boot_addr(boot_addr),
    .boot_data(boot_data), .hex(hex), .ledr(ledr)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ALUR format, op2 in 25:18 and rd in 11:8
  function automatic logic [INSTBITS-1:0] enc_r(logic [OP2BITS-1:0] op2, regno_t rd,
                                                regno_t rs, regno_t rt);
    return {OP1_ALUR, op2, 6'b000000, rd, rs, rt};
  endfunction

  // Immediate format, also loads, stores, branches and JAL
  function automatic logic [INSTBITS-1:0] enc_i(logic [OP1BITS-1:0] op1,
                                                logic [IMMBITS-1:0] imm, regno_t rs, regno_t rt);
    return {op1, 2'b00, imm, rs, rt};
  endfunction

  // Reference results for the ALUR group
  function automatic word_t alur_ref(logic [OP2BITS-1:0] op2, word_t a, word_t b);
    case (op2)
      OP2_EQ:   return (a == b) ? 32'd1 : 32'd0;
      OP2_LT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP2_LE:   return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      OP2_NE:   return (a != b) ? 32'd1 : 32'd0;
      OP2_ADD:  return a + b;
      OP2_AND:  return a & b;
      OP2_OR:   return a | b;
      OP2_XOR:  return a ^ b;
      OP2_SUB:  return a - b;
      OP2_NAND: return ~(a & b);
      OP2_NOR:  return ~(a | b);
      OP2_NXOR: return ~(a ^ b);
      OP2_RSHF: return word_t'($signed(a) >>> b[4:0]);   // Sign fills from the left
      OP2_LSHF: return a << b[4:0];
      default:  return '0;
    endcase
  endfunction

  function automatic word_t sext(logic [IMMBITS-1:0] imm);
    return {{(DBITS-IMMBITS){imm[IMMBITS-1]}}, imm};
  endfunction

  task automatic emit(logic [INSTBITS-1:0] inst);
    prog.push_back(inst);
  endtask

  // Full 32-bit constant from two sign-extended halves, r15 as scratch
  task automatic emit_const(regno_t r, word_t v);
    logic [IMMBITS-1:0] lo;
    logic [IMMBITS-1:0] hi;
    lo = v[15:0];
    hi = v[31:16] + {15'b0, lo[15]};   // Undo the borrow of a negative low half
    emit(enc_i(OP1_ADDI, hi, 4'd0, r));
    emit(enc_i(OP1_ADDI, 16'd16, 4'd0, 4'd15));
    emit(enc_r(OP2_LSHF, r, r, 4'd15));
    emit(enc_i(OP1_ADDI, lo, r, r));
  endtask

  // Value in r3 goes out as hex = bits 23:0, then ledr = {2'b10, bits 31:24}
  task automatic emit_report();
    emit(enc_i(OP1_ADDI, 16'hF000, 4'd0, 4'd14));   // r14 = ADDRHEX
    emit(enc_i(OP1_SW, 16'h0000, 4'd14, 4'd3));
    emit(enc_i(OP1_ADDI, 16'd24, 4'd0, 4'd5));
    emit(enc_r(OP2_RSHF, 4'd4, 4'd3, 4'd5));
    emit(enc_i(OP1_ANDI, 16'h00FF, 4'd4, 4'd4));
    emit(enc_i(OP1_ORI, 16'h0200, 4'd4, 4'd4));      // Bit 9 flags done
    emit(enc_i(OP1_SW, 16'h0020, 4'd14, 4'd4));     // ADDRLEDR
    emit(enc_i(OP1_BEQ, 16'hFFFF, 4'd0, 4'd0));     // Spin on itself
  endtask

  // Boot writes under reset, then release
  task automatic run_program();
    @(posedge clk);
    reset <= 1'b1;
    foreach (prog[i])
    begin
      boot_we   <= 1'b1;
      boot_addr <= IMEMADDRBITS'(STARTPC + 4 * i);
      boot_data <= prog[i];
      @(posedge clk);
    end
    boot_we <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic compare_word(string name, logic [HEXBITS-1:0] actual,
                              logic [HEXBITS-1:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic compare_led(string name, logic [LEDRBITS-1:0] actual,
                             logic [LEDRBITS-1:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Poll the done bit, then check both outputs against the reported value
  task automatic check_value(word_t v);
    int  cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < TIMEOUT)
    begin
      @(negedge clk);   // Outputs settled here
      done = ledr[LEDRBITS-1];
      cycles++;
    end
    if (!done)
    begin
      errors++;
      $display("Timed out at %0t ns: program never wrote its result to ledr", $time);
    end
    else
    begin
      compare_word("hex", hex, v[HEXBITS-1:0]);
      compare_led("ledr", ledr, {2'b10, v[31:24]});
    end
  endtask

  task automatic test_done(string name, int err0);
    if (errors == err0)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic test_reset_values();
    int err0;
    err0 = errors;
    @(negedge clk);   // Still in reset
    compare_word("hex", hex, HEX_RESET);
    compare_led("ledr", ledr, '0);
    test_done("reset_values", err0);
  endtask

  task automatic test_alur();
    logic [OP2BITS-1:0] ops [14] = '{OP2_ADD, OP2_SUB, OP2_AND, OP2_OR, OP2_XOR,
                                     OP2_NAND, OP2_NOR, OP2_NXOR, OP2_EQ, OP2_LT,
                                     OP2_LE, OP2_NE, OP2_RSHF, OP2_LSHF};
    word_t a;
    word_t b;
    int    err0;
    err0 = errors;
    foreach (ops[i])
    begin
      a = lcg_next();
      b = lcg_next();
      if (ops[i] == OP2_RSHF || ops[i] == OP2_LSHF)
        b = b & 32'd31;                 // Useful shift range
      if (ops[i] == OP2_RSHF)
        a[DBITS-1] = 1'b1;              // Negative, so the sign fill shows
      if (ops[i] == OP2_EQ || ops[i] == OP2_LE)
        b = a;                          // Equal case gives 1
      prog.delete();
      emit_const(4'd1, a);
      emit_const(4'd2, b);
      emit(enc_r(ops[i], 4'd3, 4'd1, 4'd2));   // Right behind r2, stalls
      emit_report();
      run_program();
      check_value(alur_ref(ops[i], a, b));
    end
    test_done("alur", err0);
  endtask

  task automatic test_imm();
    logic [OP1BITS-1:0] ops [4] = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
    logic [IMMBITS-1:0] imm;
    word_t              a;
    word_t              expv;
    int                 err0;
    err0 = errors;
    foreach (ops[i])
    begin
      a   = lcg_next();
      imm = IMMBITS'(lcg_next()) | 16'h8000;   // Always negative
      case (ops[i])
        OP1_ADDI: expv = a + sext(imm);
        OP1_ANDI: expv = a & sext(imm);
        OP1_ORI:  expv = a | sext(imm);
        default:  expv = a ^ sext(imm);
      endcase
      prog.delete();
      emit_const(4'd1, a);
      emit(enc_i(ops[i], imm, 4'd1, 4'd3));
      emit_report();
      run_program();
      check_value(expv);
    end
    test_done("imm", err0);
  endtask

  task automatic test_mem();
    word_t              dv;
    logic [KEYBITS-1:0] kval;
    int                 err0;
    err0 = errors;
    dv = lcg_next();
    prog.delete();
    emit_const(4'd6, dv);
    emit(enc_i(OP1_SW, 16'h0040, 4'd0, 4'd6));   // dmem word 0x40
    emit(enc_i(OP1_LW, 16'h0040, 4'd0, 4'd3));
    emit_report();
    run_program();
    check_value(dv);
    kval = KEYBITS'(lcg_next());
    @(posedge clk);
    key <= kval;
    prog.delete();
    emit(enc_i(OP1_ADDI, 16'hF000, 4'd0, 4'd14));
    emit(enc_i(OP1_LW, 16'h0080, 4'd14, 4'd3));  // ADDRKEY
    emit_report();
    run_program();
    check_value({{(DBITS-KEYBITS){1'b0}}, ~kval});
    test_done("mem_key", err0);
  endtask

  task automatic test_branch();
    int err0;
    err0 = errors;
    prog.delete();
    emit(enc_i(OP1_ADDI, 16'hF000, 4'd0, 4'd14));
    emit(enc_i(OP1_ADDI, 16'h03FF, 4'd0, 4'd7));   // Early done on ledr if a skip fails
    emit(enc_i(OP1_ADDI, 16'd5, 4'd0, 4'd1));
    emit(enc_i(OP1_ADDI, 16'd5, 4'd0, 4'd2));
    emit(enc_i(OP1_ADDI, 16'hFFFD, 4'd0, 4'd8));  // -3
    emit(enc_i(OP1_ADDI, 16'd0, 4'd0, 4'd3));
    emit(enc_i(OP1_BEQ, 16'd1, 4'd1, 4'd2));
    emit(enc_i(OP1_SW, 16'h0020, 4'd14, 4'd7));
    emit(enc_i(OP1_BLT, 16'd1, 4'd8, 4'd1));       // Signed, -3 < 5
    emit(enc_i(OP1_SW, 16'h0020, 4'd14, 4'd7));
    emit(enc_i(OP1_BNE, 16'd1, 4'd1, 4'd2));       // Falls through
    emit(enc_i(OP1_ADDI, 16'h0010, 4'd3, 4'd3));
    emit(enc_i(OP1_ADDI, 16'h0001, 4'd3, 4'd3));
    emit_report();
    run_program();
    check_value(32'h0000_0011);
    // JAL from STARTPC to STARTPC + 8, r0 base
    prog.delete();
    emit(enc_i(OP1_JAL, 16'(STARTPC / 4 + 2), 4'd0, 4'd3));
    emit(enc_i(OP1_ADDI, 16'h0777, 4'd0, 4'd3));   // Skipped
    emit_report();
    run_program();
    check_value(STARTPC + 32'd4);
    test_done("branch_jal", err0);
  endtask

  task automatic test_r0();
    int err0;
    err0 = errors;
    prog.delete();
    emit(enc_i(OP1_ADDI, 16'h0055, 4'd0, 4'd0));
    emit(enc_i(OP1_ADDI, 16'd9, 4'd0, 4'd1));
    emit(enc_r(OP2_ADD, 4'd0, 4'd1, 4'd1));
    emit(enc_i(OP1_ADDI, 16'd7, 4'd0, 4'd3));     // Sum shows r0 still zero
    emit_report();
    run_program();
    check_value(32'd7);
    test_done("r0_write", err0);
  endtask

  initial
  begin
    reset     = 1'b1;
    key       = '0;
    boot_we   = 1'b0;
    boot_addr = '0;
    boot_data = '0;
    lcg_state = 32'h5112268b;
    checks    = 0;
    errors    = 0;
    repeat (2) @(posedge clk);
    test_reset_values();
    test_alur();
    test_imm();
    test_mem();
    test_branch();
    test_r0();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [cpu_pkg::KEYBITS-1:0]      key,
  input  logic                             boot_we,
  input  logic [cpu_pkg::IMEMADDRBITS-1:0] boot_addr,
  input  logic [cpu_pkg::INSTBITS-1:0]     boot_data,
  output logic [cpu_pkg::HEXBITS-1:0]      hex,
  output logic [cpu_pkg::LEDRBITS-1:0]     ledr
);
  import cpu_pkg::*;

  fe_id_t    fe_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb;
  redirect_t redirect;     // Execute to fetch and decode
  regno_t    rs;
  regno_t    rt;
  regno_t    ex_wregno;
  regno_t    mem_wregno;
  word_t     rval_a;
  word_t     rval_b;
  logic      stall;
  logic      hold_fetch;

  fetch_stage u_fetch (
    .clk(clk), .reset(reset), .boot_we(boot_we), .boot_addr(boot_addr),
    .boot_data(boot_data), .stall(stall), .hold_fetch(hold_fetch),
    .redirect(redirect), .fe_id(fe_id)
  );

  decode_stage u_decode (
    .clk(clk), .reset(reset), .fe_id(fe_id), .rval_a(rval_a), .rval_b(rval_b),
    .redirect(redirect), .ex_wregno(ex_wregno), .mem_wregno(mem_wregno),
    .rs(rs), .rt(rt), .stall(stall), .hold_fetch(hold_fetch), .id_ex(id_ex)
  );

  // Written from the memory/writeback register
  reg_file u_regs (
    .clk(clk), .reset(reset), .rs(rs), .rt(rt), .wb(wb),
    .rval_a(rval_a), .rval_b(rval_b)
  );

  execute_stage u_execute (
    .clk(clk), .reset(reset), .id_ex(id_ex), .redirect(redirect),
    .ex_mem(ex_mem), .ex_wregno(ex_wregno)
  );

  memory_stage u_memory (
    .clk(clk), .reset(reset), .ex_mem(ex_mem), .key(key), .wb(wb),
    .mem_wregno(mem_wregno), .hex(hex), .ledr(ledr)
  );

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  cpu_pkg::ex_mem_t              ex_mem,
  input  logic [cpu_pkg::KEYBITS-1:0]   key,
  output cpu_pkg::wb_t                  wb,
  output cpu_pkg::regno_t               mem_wregno,
  output logic [cpu_pkg::HEXBITS-1:0]   hex,
  output logic [cpu_pkg::LEDRBITS-1:0]  ledr
);
  import cpu_pkg::*;

  word_t dmem [DMEMWORDS];
  word_t addr;
  word_t dmem_rdata;
  word_t load_val;
  logic  sel_hex;
  logic  sel_ledr;
  logic  sel_key;
  logic  sel_dmem;

  // Address decode
  assign addr     = ex_mem.result;
  assign sel_hex  = (addr == ADDRHEX);
  assign sel_ledr = (addr == ADDRLEDR);
  assign sel_key  = (addr == ADDRKEY);
  assign sel_dmem = !(sel_hex || sel_ledr || sel_key);

  assign dmem_rdata = dmem[addr[DMEMADDRBITS-1:2]];

  // I/O stores never alias into RAM
  always_ff @(posedge clk)
  begin
    if (ex_mem.wr_mem && sel_dmem)
      dmem[addr[DMEMADDRBITS-1:2]] <= ex_mem.sdata;
  end

  // Keys are active low on the board
  assign load_val = sel_key ? {{(DBITS-KEYBITS){1'b0}}, ~key} : dmem_rdata;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hex  <= HEX_RESET;
      ledr <= '0;
    end
    else if (ex_mem.wr_mem)
    begin
      if (sel_hex)
        hex <= ex_mem.sdata[HEXBITS-1:0];
      if (sel_ledr)
        ledr <= ex_mem.sdata[LEDRBITS-1:0];
    end
  end

  // Memory/writeback register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      wb <= '0;
    else
    begin
      wb.wregno <= ex_mem.wregno;
      wb.value  <= ex_mem.rd_mem ? load_val : ex_mem.result;
      wb.wr_reg <= ex_mem.wr_reg;
    end
  end

  assign mem_wregno = wb.wregno;

  // Decode gives each opcode at most one memory direction
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.rd_mem && ex_mem.wr_mem));

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::id_ex_t    id_ex,
  output cpu_pkg::redirect_t redirect,
  output cpu_pkg::ex_mem_t   ex_mem,
  output cpu_pkg::regno_t    ex_wregno
);
  import cpu_pkg::*;

  word_t a;
  word_t b;
  word_t imm;
  word_t pc_plus;   // Own address + 4, also the JAL link
  word_t imm_x4;
  word_t alu_out;
  logic  br_cond;

  assign a       = id_ex.a;
  assign b       = id_ex.b;
  assign imm     = id_ex.imm;
  assign pc_plus = id_ex.pc + 32'd4;
  assign imm_x4  = {imm[DBITS-3:0], 2'b00};

  always_comb
  begin
    case (id_ex.op1)
      OP1_ALUR:
        case (id_ex.op2)
          OP2_EQ:   alu_out = word_t'(a == b);
          OP2_LT:   alu_out = word_t'($signed(a) < $signed(b));
          OP2_LE:   alu_out = word_t'($signed(a) <= $signed(b));
          OP2_NE:   alu_out = word_t'(a != b);
          OP2_ADD:  alu_out = a + b;
          OP2_AND:  alu_out = a & b;
          OP2_OR:   alu_out = a | b;
          OP2_XOR:  alu_out = a ^ b;
          OP2_SUB:  alu_out = a - b;
          OP2_NAND: alu_out = ~(a & b);
          OP2_NOR:  alu_out = ~(a | b);
          OP2_NXOR: alu_out = ~(a ^ b);
          OP2_RSHF: alu_out = $signed(a) >>> b;   // Arithmetic
          OP2_LSHF: alu_out = a << b;
          default:  alu_out = '0;                 // NOP lands here
        endcase
      OP1_LW, OP1_SW, OP1_ADDI: alu_out = a + imm;   // Address or sum
      OP1_ANDI: alu_out = a & imm;
      OP1_ORI:  alu_out = a | imm;
      OP1_XORI: alu_out = a ^ imm;
      default:  alu_out = '0;
    endcase
  end

  // Signed branch compare
  always_comb
  begin
    case (id_ex.op1)
      OP1_BEQ: br_cond = (a == b);
      OP1_BLT: br_cond = ($signed(a) < $signed(b));
      OP1_BLE: br_cond = ($signed(a) <= $signed(b));
      OP1_BNE: br_cond = (a != b);
      default: br_cond = 1'b0;
    endcase
  end

  // Not-taken branches stay silent, fetch already holds branch+4
  assign redirect = '{
    valid:  id_ex.ctrl.is_jmp || (id_ex.ctrl.is_br && br_cond),
    target: id_ex.ctrl.is_jmp ? a + imm_x4 : pc_plus + imm_x4
  };

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
    begin
      ex_mem.result <= id_ex.ctrl.is_jmp ? pc_plus : alu_out;   // JAL links
      ex_mem.sdata  <= b;
      ex_mem.wregno <= id_ex.wregno;
      ex_mem.rd_mem <= id_ex.ctrl.rd_mem;
      ex_mem.wr_mem <= id_ex.ctrl.wr_mem;
      ex_mem.wr_reg <= id_ex.ctrl.wr_reg;
    end
  end

  assign ex_wregno = ex_mem.wregno;   // For the decode hazard check

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::regno_t rs,
  input  cpu_pkg::regno_t rt,
  input  cpu_pkg::wb_t    wb,
  output cpu_pkg::word_t  rval_a,
  output cpu_pkg::word_t  rval_b
);
  import cpu_pkg::*;

  word_t regs [REGWORDS];
  logic  wr_en;

  assign wr_en = wb.wr_reg && (wb.wregno != '0);   // r0 is read-only

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < REGWORDS; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
      regs[wb.wregno] <= wb.value;
  end

  // Writeback value passes straight through to a matching read
  assign rval_a = (rs == '0)                   ? '0       :
                  (wr_en && wb.wregno == rs)   ? wb.value :
                                                 regs[rs];
  assign rval_b = (rt == '0)                   ? '0       :
                  (wr_en && wb.wregno == rt)   ? wb.value :
                                                 regs[rt];

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::fe_id_t    fe_id,
  input  cpu_pkg::word_t     rval_a,
  input  cpu_pkg::word_t     rval_b,
  input  cpu_pkg::redirect_t redirect,
  input  cpu_pkg::regno_t    ex_wregno,
  input  cpu_pkg::regno_t    mem_wregno,
  output cpu_pkg::regno_t    rs,
  output cpu_pkg::regno_t    rt,
  output logic               stall,
  output logic               hold_fetch,
  output cpu_pkg::id_ex_t    id_ex
);
  import cpu_pkg::*;

  logic [OP1BITS-1:0] op1;
  logic [OP2BITS-1:0] op2;
  logic [IMMBITS-1:0] imm16;
  regno_t             rd;
  regno_t             wregno;
  word_t              sxt_imm;
  ctrl_t              ctrl;
  logic               is_alur;
  logic               is_imm;
  logic               use_rs;
  logic               use_rt;
  logic               hit_rs;
  logic               hit_rt;

  // Instruction fields
  assign op1   = fe_id.inst[31:26];
  assign op2   = fe_id.inst[25:18];
  assign imm16 = fe_id.inst[23:8];   // Overlaps op2 and rd
  assign rd    = fe_id.inst[11:8];
  assign rs    = fe_id.inst[7:4];
  assign rt    = fe_id.inst[3:0];

  assign sxt_imm = {{(DBITS-IMMBITS){imm16[IMMBITS-1]}}, imm16};

  assign is_alur = (op1 == OP1_ALUR);
  assign is_imm  = op1[OP1BITS-1];   // ADDI, ANDI, ORI, XORI

  always_comb
  begin
    ctrl.is_br  = (op1[OP1BITS-1:2] == OP1_BEQ[OP1BITS-1:2]);  // Four compare branches
    ctrl.is_jmp = (op1 == OP1_JAL);
    ctrl.rd_mem = (op1 == OP1_LW);
    ctrl.wr_mem = (op1 == OP1_SW);
    ctrl.wr_reg = !(ctrl.is_br || ctrl.wr_mem);
  end

  // Destination register
  always_comb
  begin
    if (is_alur)
      wregno = rd;
    else if (ctrl.is_br || ctrl.wr_mem)
      wregno = '0;      // Nothing written back
    else
      wregno = rt;      // Immediates, LW, JAL
  end

  // Which sources are really read
  assign use_rt = is_alur || ctrl.is_br || ctrl.wr_mem;
  assign use_rs = use_rt || ctrl.is_jmp || ctrl.rd_mem || is_imm;

  // Match against destinations still in flight, r0 never blocks
  assign hit_rs = (rs != '0) &&
                  ((rs == id_ex.wregno) || (rs == ex_wregno) || (rs == mem_wregno));
  assign hit_rt = (rt != '0) &&
                  ((rt == id_ex.wregno) || (rt == ex_wregno) || (rt == mem_wregno));

  assign stall      = (use_rs && hit_rs) || (use_rt && hit_rt);
  assign hold_fetch = ctrl.is_br || ctrl.is_jmp;   // Wait for execute to resolve

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else if (stall || redirect.valid)
      id_ex <= '0;     // Bubble, all-zero carries no write
    else
    begin
      id_ex.pc     <= fe_id.pc;
      id_ex.op1    <= op1;
      id_ex.op2    <= op2;
      id_ex.a      <= rval_a;
      id_ex.b      <= rval_b;
      id_ex.imm    <= sxt_imm;
      id_ex.wregno <= wregno;
      id_ex.ctrl   <= ctrl;
    end
  end

  // A stalled instruction keeps its place in decode until its sources are free
  a_stall_holds: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(fe_id));

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             boot_we,
  input  logic [cpu_pkg::IMEMADDRBITS-1:0] boot_addr,
  input  logic [cpu_pkg::INSTBITS-1:0]     boot_data,
  input  logic                             stall,
  input  logic                             hold_fetch,
  input  cpu_pkg::redirect_t               redirect,
  output cpu_pkg::fe_id_t                  fe_id
);
  import cpu_pkg::*;

  word_t               pc;       // Address being fetched
  word_t               pc_plus;
  logic [INSTBITS-1:0] inst_w;
  logic                bubble;   // Load a NOP into fetch/decode

  // Instruction memory, word indexed
  logic [INSTBITS-1:0] imem [IMEMWORDS];

  // Loader port, usable in any cycle including reset
  always_ff @(posedge clk)
  begin
    if (boot_we)
      imem[boot_addr[IMEMADDRBITS-1:2]] <= boot_data;
  end

  assign inst_w  = imem[pc[IMEMADDRBITS-1:2]];  // Async read
  assign pc_plus = pc + 32'd4;

  // Stall keeps the decode slot, so hold_fetch only bubbles without it
  assign bubble = redirect.valid || (hold_fetch && !stall);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= STARTPC;
    else if (redirect.valid)
      pc <= redirect.target;   // Taken branch or JAL
    else if (!(stall || hold_fetch))
      pc <= pc_plus;
    // Otherwise PC holds, branch+4 stays ready for the not-taken case
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fe_id <= '{pc: '0, inst: NOP};
    else if (bubble)
      fe_id <= '{pc: '0, inst: NOP};
    else if (!stall)
      fe_id <= '{pc: pc, inst: inst_w};
  end

  // Alignment has to survive every PC source, JAL targets from rs included
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

  // Word and field widths
  localparam int DBITS     = 32;
  localparam int INSTBITS  = 32;
  localparam int REGNOBITS = 4;
  localparam int REGWORDS  = 1 << REGNOBITS;
  localparam int IMMBITS   = 16;
  localparam int OP1BITS   = 6;
  localparam int OP2BITS   = 8;

  // Byte-address bits per memory, 1024 words each
  localparam int IMEMADDRBITS = 12;
  localparam int DMEMADDRBITS = 12;
  localparam int IMEMWORDS    = 1 << (IMEMADDRBITS - 2);
  localparam int DMEMWORDS    = 1 << (DMEMADDRBITS - 2);

  // Board I/O widths
  localparam int HEXBITS  = 24;
  localparam int LEDRBITS = 10;
  localparam int KEYBITS  = 4;

  localparam logic [DBITS-1:0]   STARTPC   = 32'h0000_0100;  // Reset PC
  localparam logic [DBITS-1:0]   ADDRHEX   = 32'hFFFF_F000;
  localparam logic [DBITS-1:0]   ADDRLEDR  = 32'hFFFF_F020;
  localparam logic [DBITS-1:0]   ADDRKEY   = 32'hFFFF_F080;
  localparam logic [HEXBITS-1:0] HEX_RESET = 24'hFEDEAD;

  // Primary opcodes, inst[31:26]
  localparam logic [OP1BITS-1:0] OP1_ALUR = 6'b000000;
  localparam logic [OP1BITS-1:0] OP1_BEQ  = 6'b001000;
  localparam logic [OP1BITS-1:0] OP1_BLT  = 6'b001001;
  localparam logic [OP1BITS-1:0] OP1_BLE  = 6'b001010;
  localparam logic [OP1BITS-1:0] OP1_BNE  = 6'b001011;
  localparam logic [OP1BITS-1:0] OP1_JAL  = 6'b001100;
  localparam logic [OP1BITS-1:0] OP1_LW   = 6'b010010;
  localparam logic [OP1BITS-1:0] OP1_SW   = 6'b011010;
  localparam logic [OP1BITS-1:0] OP1_ADDI = 6'b100000;
  localparam logic [OP1BITS-1:0] OP1_ANDI = 6'b100100;
  localparam logic [OP1BITS-1:0] OP1_ORI  = 6'b100101;
  localparam logic [OP1BITS-1:0] OP1_XORI = 6'b100110;

  // Secondary opcodes for ALUR, inst[25:18]
  localparam logic [OP2BITS-1:0] OP2_EQ   = 8'b00001000;
  localparam logic [OP2BITS-1:0] OP2_LT   = 8'b00001001;
  localparam logic [OP2BITS-1:0] OP2_LE   = 8'b00001010;
  localparam logic [OP2BITS-1:0] OP2_NE   = 8'b00001011;
  localparam logic [OP2BITS-1:0] OP2_ADD  = 8'b00100000;
  localparam logic [OP2BITS-1:0] OP2_AND  = 8'b00100100;
  localparam logic [OP2BITS-1:0] OP2_OR   = 8'b00100101;
  localparam logic [OP2BITS-1:0] OP2_XOR  = 8'b00100110;
  localparam logic [OP2BITS-1:0] OP2_SUB  = 8'b00101000;
  localparam logic [OP2BITS-1:0] OP2_NAND = 8'b00101100;
  localparam logic [OP2BITS-1:0] OP2_NOR  = 8'b00101101;
  localparam logic [OP2BITS-1:0] OP2_NXOR = 8'b00101110;
  localparam logic [OP2BITS-1:0] OP2_RSHF = 8'b00110000;
  localparam logic [OP2BITS-1:0] OP2_LSHF = 8'b00110001;

  localparam logic [INSTBITS-1:0] NOP = '0;  // ALUR with op2 0, writes r0

  typedef logic [DBITS-1:0]     word_t;
  typedef logic [REGNOBITS-1:0] regno_t;

  typedef struct packed {
    logic is_br;   // BEQ, BLT, BLE, BNE
    logic is_jmp;  // JAL
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  typedef struct packed {
    word_t               pc;    // Address of inst
    logic [INSTBITS-1:0] inst;
  } fe_id_t;

  typedef struct packed {
    word_t              pc;
    logic [OP1BITS-1:0] op1;
    logic [OP2BITS-1:0] op2;
    word_t              a;       // regs[rs]
    word_t              b;       // regs[rt]
    word_t              imm;     // Sign-extended
    regno_t             wregno;
    ctrl_t              ctrl;
  } id_ex_t;

  typedef struct packed {
    word_t  result;  // ALU value, address or link
    word_t  sdata;   // Store data
    regno_t wregno;
    logic   rd_mem;
    logic   wr_mem;
    logic   wr_reg;
  } ex_mem_t;

  typedef struct packed {
    regno_t wregno;
    word_t  value;
    logic   wr_reg;
  } wb_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

endpackage
